/* bench/axi_rd_mem.sv */
module axi_rd_mem import icache_pkg::*; #(
   parameter logic [31:0] DATA_KEY = 32'h0000_0000,
   parameter logic [31:0] SEED     = 32'h0000_0001
) (
   input  logic  clk,
   input  logic  reset,
   input  addr_t i_araddr,
   input  logic  i_arvalid,
   output logic  o_arready,
   output word_t o_rdata,
   output logic  o_rvalid,
   output logic  o_rlast
);

   integer     seed = SEED;
   logic       busy = 1'b0;
   addr_t      base = '0;
   int         sent = 0;
   int         sent_now;
   logic [2:0] slot;
   logic       arready_q = 1'b0;
   word_t      rdata_q = '0;
   logic       rvalid_q = 1'b0;
   logic       rlast_q = 1'b0;

   assign o_arready = arready_q;
   assign o_rdata   = rdata_q;
   assign o_rvalid  = rvalid_q;
   assign o_rlast   = rlast_q;

   //////////////////////////////
   // address accept and burst
   //////////////////////////////

   always @(posedge clk) begin
      if (reset) begin
         busy      <= 1'b0;
         arready_q <= 1'b0;
         rvalid_q  <= 1'b0;
         rlast_q   <= 1'b0;
         sent      <= 0;
      end else if (!busy) begin
         rvalid_q <= 1'b0;
         rlast_q  <= 1'b0;
         if (i_arvalid && arready_q) begin
            busy      <= 1'b1;
            base      <= i_araddr;
            sent      <= 0;
            arready_q <= 1'b0;
         end else begin
            // ready on about half the cycles
            arready_q <= ($random(seed) & 1) == 1;
         end
      end else begin
         // the beat on the bus this cycle is always taken
         sent_now = sent + (rvalid_q ? 1 : 0);
         if (sent_now == BURST_BEATS) begin
            busy     <= 1'b0;
            rvalid_q <= 1'b0;
            rlast_q  <= 1'b0;
         end else if (($random(seed) & 3) == 0) begin
            rvalid_q <= 1'b0;
            rlast_q  <= 1'b0;
         end else begin
            // wrap inside the line from the first word
            slot = base[4:2] + sent_now[2:0];
            rdata_q  <= {base[31:5], slot, 2'b00} ^ DATA_KEY;
            rvalid_q <= 1'b1;
            rlast_q  <= (sent_now == BURST_BEATS - 1);
         end
         sent <= sent_now;
      end
   end

endmodule

/* bench/icache_tb.sv */
module icache_tb import icache_pkg::*;;

   localparam logic [31:0] DATA_KEY = 32'h5a3c_96e1;

   logic  clk;
   logic  reset;
   logic  i_flush;
   logic  i_req_valid;
   addr_t i_req_addr;
   logic  o_stall;
   logic  o_rsp_valid;
   word_t o_rsp_data;
   addr_t o_araddr;
   logic  o_arvalid;
   logic  i_arready;
   word_t i_rdata;
   logic  i_rvalid;
   logic  i_rlast;

   // stimulus table
   string row_name[$];
   addr_t row_addr[$];
   logic  row_flush[$];
   logic  row_miss[$];

   // rows waiting for a response in request order
   int    exp_q[$];
   // lru model prediction for each row in exp_q
   logic  model_q[$];
   int    bursts = 0;
   int    bursts_at_rsp = 0;
   int    err_data = 0;
   int    err_miss = 0;
   int    err_other = 0;

   // two-way lru reference
   logic [TAG_W-1:0] m_tag [NUM_WAYS][1 << INDEX_W];
   logic             m_valid [NUM_WAYS][1 << INDEX_W];
   logic             m_lru [1 << INDEX_W];

   int    head;
   logic  head_model;
   addr_t head_addr;
   word_t exp_data;
   logic  saw_miss;

   icache_top u_icache_top (
      .clk         (clk),
      .reset       (reset),
      .i_flush     (i_flush),
      .i_req_valid (i_req_valid),
      .i_req_addr  (i_req_addr),
      .o_stall     (o_stall),
      .o_rsp_valid (o_rsp_valid),
      .o_rsp_data  (o_rsp_data),
      .o_araddr    (o_araddr),
      .o_arvalid   (o_arvalid),
      .i_arready   (i_arready),
      .i_rdata     (i_rdata),
      .i_rvalid    (i_rvalid),
      .i_rlast     (i_rlast)
   );

   axi_rd_mem #(.DATA_KEY(DATA_KEY), .SEED(32'hbf58_6b6d)) u_mem (
      .clk       (clk),
      .reset     (reset),
      .i_araddr  (o_araddr),
      .i_arvalid (o_arvalid),
      .o_arready (i_arready),
      .o_rdata   (i_rdata),
      .o_rvalid  (i_rvalid),
      .o_rlast   (i_rlast)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   //////////////////////////////
   // table and lru reference
   //////////////////////////////

   task automatic add_row(input string n, input addr_t a, input logic f, input logic m);
      row_name.push_back(n);
      row_addr.push_back(a);
      row_flush.push_back(f);
      row_miss.push_back(m);
   endtask

   task automatic build_table();
      add_row("cold_miss",    32'h0000_1004, 1'b0, 1'b1);
      add_row("line_word0",   32'h0000_1000, 1'b0, 1'b0);
      add_row("line_word2",   32'h0000_1008, 1'b0, 1'b0);
      add_row("line_word3",   32'h0000_100c, 1'b0, 1'b0);
      add_row("line_word4",   32'h0000_1010, 1'b0, 1'b0);
      add_row("line_word5",   32'h0000_1014, 1'b0, 1'b0);
      add_row("line_word6",   32'h0000_1018, 1'b0, 1'b0);
      add_row("line_word7",   32'h0000_101c, 1'b0, 1'b0);
      add_row("b2b_miss_a",   32'h0000_2044, 1'b0, 1'b1);
      add_row("b2b_miss_b",   32'h0000_3068, 1'b0, 1'b1);
      add_row("b2b_hit_b",    32'h0000_3060, 1'b0, 1'b0);
      add_row("wrap_miss",    32'h0000_71fc, 1'b0, 1'b1);
      add_row("wrap_hit",     32'h0000_71e0, 1'b0, 1'b0);
      add_row("set5_a",       32'h0000_40a0, 1'b0, 1'b1);
      add_row("set5_b",       32'h0000_50a4, 1'b0, 1'b1);
      add_row("set5_a_hit",   32'h0000_40a8, 1'b0, 1'b0);
      add_row("set5_c",       32'h0000_60ac, 1'b0, 1'b1);
      add_row("set5_a_keep",  32'h0000_40b0, 1'b0, 1'b0);
      add_row("set5_b_back",  32'h0000_50b4, 1'b0, 1'b1);
      add_row("set5_c_back",  32'h0000_60b8, 1'b0, 1'b1);
      add_row("set5_b_stay",  32'h0000_50bc, 1'b0, 1'b0);
      add_row("flush_all",    32'h0000_0000, 1'b1, 1'b0);
      add_row("flush_refill", 32'h0000_1010, 1'b0, 1'b1);
      add_row("flush_hit",    32'h0000_101c, 1'b0, 1'b0);
      add_row("flush_set5",   32'h0000_50a0, 1'b0, 1'b1);
      add_row("far_miss",     32'habcd_e3e4, 1'b0, 1'b1);
      add_row("far_hit",      32'habcd_e3f8, 1'b0, 1'b0);
   endtask

   function automatic logic lru_lookup(input addr_t a);
      int         s;
      logic [19:0] t;
      logic       v;
      s = int'(a[11:5]);
      t = a[31:12];
      for (int w = 0; w < NUM_WAYS; w++) begin
         if (m_valid[w][s] && m_tag[w][s] == t) begin
            m_lru[s] = (w == 0);
            return 1'b0;
         end
      end
      // miss fills the way the lru bit names
      v = m_lru[s];
      m_tag[v][s]   = t;
      m_valid[v][s] = 1'b1;
      m_lru[s]      = ~v;
      return 1'b1;
   endfunction

   function automatic void clear_model();
      for (int s = 0; s < (1 << INDEX_W); s++) begin
         m_valid[0][s] = 1'b0;
         m_valid[1][s] = 1'b0;
         m_lru[s]      = 1'b0;
      end
   endfunction

   //////////////////////////////
   // request driving
   //////////////////////////////

   task automatic wait_accept();
      logic stalled;
      do begin
         @(negedge clk);
         stalled = o_stall;
         @(posedge clk);
      end while (stalled);
   endtask

   task automatic wait_idle();
      logic stalled;
      do begin
         @(negedge clk);
         stalled = o_stall;
         @(posedge clk);
      end while (stalled || exp_q.size() != 0);
   endtask

   task automatic send_request(input int r);
      i_req_valid <= 1'b1;
      i_req_addr  <= row_addr[r];
      wait_accept();
      exp_q.push_back(r);
      model_q.push_back(lru_lookup(row_addr[r]));
   endtask

   task automatic flush_cache();
      i_req_valid <= 1'b0;
      wait_idle();
      i_flush <= 1'b1;
      @(posedge clk);
      i_flush <= 1'b0;
      clear_model();
   endtask

   //////////////////////////////
   // response and burst checks
   //////////////////////////////

   always @(negedge clk) begin
      if (!reset) begin
         if (o_arvalid && i_arready) begin
            bursts++;
            if (exp_q.size() == 0) begin
               $display("a burst was issued with no request outstanding");
               err_other++;
            end else begin
               head_addr = row_addr[exp_q[0]];
               if (o_araddr != {head_addr[31:2], 2'b00}) begin
                  $display("error %s: araddr expected %h actual %h", row_name[exp_q[0]],
                           {head_addr[31:2], 2'b00}, o_araddr);
                  err_data++;
               end
            end
         end
         if (o_rsp_valid) begin
            if (exp_q.size() == 0) begin
               $display("a response came with no request outstanding");
               err_other++;
            end else begin
               head       = exp_q.pop_front();
               head_model = model_q.pop_front();
               head_addr  = row_addr[head];
               exp_data   = {head_addr[31:2], 2'b00} ^ DATA_KEY;
               if (o_rsp_data != exp_data) begin
                  $display("error %s: data expected %h actual %h", row_name[head],
                           exp_data, o_rsp_data);
                  err_data++;
               end
               saw_miss = (bursts != bursts_at_rsp);
               if (bursts - bursts_at_rsp > 1) begin
                  $display("%s caused more than one burst", row_name[head]);
                  err_other++;
               end
               if (saw_miss != row_miss[head]) begin
                  $display("error %s: miss expected %0d actual %0d", row_name[head],
                           row_miss[head], saw_miss);
                  err_miss++;
               end
               if (saw_miss != head_model) begin
                  $display("error %s: lru model miss expected %0d actual %0d",
                           row_name[head], head_model, saw_miss);
                  err_miss++;
               end
               bursts_at_rsp = bursts;
            end
         end
      end
   end

   // watchdog allows 60 cycles per table row
   initial begin
      @(posedge clk);
      repeat (row_name.size() * 60) @(posedge clk);
      $display("timeout: the table did not finish in %0d cycles", row_name.size() * 60);
      $display("Test failures found");
      $finish;
   end

   //////////////////////////////
   // main sequence
   //////////////////////////////

   initial begin
      reset       = 1'b1;
      i_flush     = 1'b0;
      i_req_valid = 1'b0;
      i_req_addr  = '0;
      build_table();
      clear_model();
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      if (o_stall || o_rsp_valid || o_arvalid) begin
         $display("stall, response or address valid is high after reset");
         err_other++;
      end
      @(posedge clk);
      for (int r = 0; r < row_name.size(); r++) begin
         if (row_flush[r]) begin
            flush_cache();
         end else begin
            send_request(r);
         end
      end
      i_req_valid <= 1'b0;
      wait_idle();
      $display("errors: data %0d, miss %0d, other %0d", err_data, err_miss, err_other);
      if (err_data + err_miss + err_other == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"
rm -f sim.log

verilator --binary --timing --assert --top-module icache_tb \
   -f verilog.f -Mdir obj_dir -o icache_sim
./obj_dir/icache_sim 2>&1 | tee sim.log

if grep -q "Test failures found" sim.log; then
   echo "simulation failed"
   exit 1
fi
echo "simulation passed"

/* source/cache_ram.sv */
module cache_ram import icache_pkg::*; #(
   parameter type entry_t = line_t
) (
   input  logic   clk,
   input  index_t i_raddr,
   output entry_t o_rdata,
   input  logic   i_we,
   input  index_t i_waddr,
   input  entry_t i_wdata
);

   // one entry per set
   localparam int DEPTH = 1 << INDEX_W;

   entry_t mem [DEPTH];

   // registered read returns old data on a same-address write
   always_ff @(posedge clk) begin
      if (i_we) begin
         mem[i_waddr] <= i_wdata;
      end
      o_rdata <= mem[i_raddr];
   end

endmodule

/* source/icache_arrays.sv */
module icache_arrays import icache_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  logic      i_flush,
   input  index_t    i_rd_index,
   input  tag_t      i_cmp_tag,
   input  word_sel_t i_word_sel,
   output way_mask_t o_hit_way,
   output word_t     o_hit_word,
   input  logic      i_fill_we,
   input  index_t    i_fill_index,
   input  tag_t      i_fill_tag,
   input  line_t     i_fill_line
);

   localparam int SETS = 1 << INDEX_W;

   logic [SETS-1:0] valid_q [NUM_WAYS];
   // lru bit holds the victim way number
   logic [SETS-1:0] lru_q;
   index_t          rd_index_q;
   tag_t            tag_rd [NUM_WAYS];
   line_t           line_rd [NUM_WAYS];
   logic            victim;

   assign victim = lru_q[i_fill_index];

   //////////////////////////////
   // per-way storage and compare
   //////////////////////////////

   for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
      logic way_we;

      assign way_we = i_fill_we && (int'(victim) == w);

      cache_ram #(.entry_t(tag_t)) u_tag_ram (
         .clk     (clk),
         .i_raddr (i_rd_index),
         .o_rdata (tag_rd[w]),
         .i_we    (way_we),
         .i_waddr (i_fill_index),
         .i_wdata (i_fill_tag)
      );

      cache_ram #(.entry_t(line_t)) u_line_ram (
         .clk     (clk),
         .i_raddr (i_rd_index),
         .o_rdata (line_rd[w]),
         .i_we    (way_we),
         .i_waddr (i_fill_index),
         .i_wdata (i_fill_line)
      );

      assign o_hit_way[w] = valid_q[w][rd_index_q] && (tag_rd[w] == i_cmp_tag);
   end

   always_comb begin
      o_hit_word = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
         if (o_hit_way[w]) begin
            o_hit_word = line_rd[w][i_word_sel];
         end
      end
   end

   // valid and lru follow the ram read by one edge
   always_ff @(posedge clk) begin
      if (reset) begin
         rd_index_q <= '0;
      end else begin
         rd_index_q <= i_rd_index;
      end
   end

   //////////////////////////////
   // valid and lru bits
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (reset || i_flush) begin
         for (int w = 0; w < NUM_WAYS; w++) begin
            valid_q[w] <= '0;
         end
         lru_q <= '0;
      end else begin
         // point away from the way that hit
         if (|o_hit_way) begin
            lru_q[rd_index_q] <= o_hit_way[0];
         end
         if (i_fill_we) begin
            valid_q[victim][i_fill_index] <= 1'b1;
            lru_q[i_fill_index]           <= ~victim;
         end
      end
   end

   // a line is never resident in both ways
   a_one_way_hit: assert property (@(posedge clk) disable iff (reset)
      o_hit_way != '1);

endmodule

/* source/icache_lookup.sv */
module icache_lookup import icache_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  logic      i_req_valid,
   input  addr_t     i_req_addr,
   output index_t    o_rd_index,
   output tag_t      o_cmp_tag,
   output word_sel_t o_word_sel,
   input  way_mask_t i_hit_way,
   input  word_t     i_hit_word,
   output logic      o_miss_start,
   output addr_t     o_miss_addr,
   input  logic      i_crit_valid,
   input  word_t     i_crit_word,
   input  logic      i_refill_busy,
   output logic      o_stall,
   output logic      o_rsp_valid,
   output word_t     o_rsp_data
);

   // stage one holds the request caught behind a miss
   logic  s1_valid_q;
   addr_t s1_addr_q;
   // stage two is the request being compared
   logic  s2_valid_q;
   addr_t s2_addr_q;

   logic  miss;
   logic  replay;
   logic  take;
   addr_t req_addr;

   //////////////////////////////
   // hit / miss and stall
   //////////////////////////////

   assign miss    = s2_valid_q && (i_hit_way == '0);
   assign o_stall = miss || i_refill_busy;

   assign replay   = s1_valid_q && !o_stall;
   assign take     = replay || (i_req_valid && !o_stall);
   assign req_addr = replay ? s1_addr_q : i_req_addr;

   // with no new request the held set is read again
   assign o_rd_index = take ? addr_index(req_addr) : addr_index(s2_addr_q);
   assign o_cmp_tag  = addr_tag(s2_addr_q);
   assign o_word_sel = addr_word(s2_addr_q);

   assign o_miss_start = miss;
   assign o_miss_addr  = s2_addr_q;

   // early restart word takes over the response
   assign o_rsp_valid = (s2_valid_q && (|i_hit_way)) || i_crit_valid;
   assign o_rsp_data  = i_crit_valid ? i_crit_word : i_hit_word;

   //////////////////////////////
   // request registers
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         s1_valid_q <= 1'b0;
         s2_valid_q <= 1'b0;
         s2_addr_q  <= '0;
      end else begin
         s2_valid_q <= take;
         if (take) begin
            s2_addr_q <= req_addr;
         end
         if (miss) begin
            s1_valid_q <= i_req_valid;
         end else if (!o_stall) begin
            s1_valid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (miss) begin
         s1_addr_q <= i_req_addr;
      end
   end

   // critical word only arrives while no lookup is in stage two
   a_rsp_no_collide: assert property (@(posedge clk) disable iff (reset)
      i_crit_valid |-> !s2_valid_q && i_refill_busy);

endmodule

/* source/icache_pkg.sv */
package icache_pkg;

   //////////////////////////////
   // widths and geometry
   //////////////////////////////

   localparam int ADDR_W      = 32;
   localparam int WORD_W      = 32;
   localparam int LINE_WORDS  = 8;
   localparam int OFFSET_W    = 5;
   localparam int INDEX_W     = 7;
   localparam int TAG_W       = ADDR_W - INDEX_W - OFFSET_W;
   localparam int NUM_WAYS    = 2;

   // refill burst is always one full line
   localparam int BURST_BEATS = 8;

   typedef logic [ADDR_W-1:0]                 addr_t;
   typedef logic [WORD_W-1:0]                 word_t;
   typedef logic [TAG_W-1:0]                  tag_t;
   typedef logic [INDEX_W-1:0]                index_t;
   typedef logic [$clog2(LINE_WORDS)-1:0]     word_sel_t;
   // word 0 sits in the low bits
   typedef logic [LINE_WORDS-1:0][WORD_W-1:0] line_t;
   typedef logic [NUM_WAYS-1:0]               way_mask_t;

   //////////////////////////////
   // address field helpers
   //////////////////////////////

   function automatic tag_t addr_tag(addr_t a);
      return a[ADDR_W-1 -: TAG_W];
   endfunction

   function automatic index_t addr_index(addr_t a);
      return a[OFFSET_W +: INDEX_W];
   endfunction

   function automatic word_sel_t addr_word(addr_t a);
      return a[OFFSET_W-1:2];
   endfunction

endpackage

/* source/icache_refill.sv */
module icache_refill import icache_pkg::*; (
   input  logic   clk,
   input  logic   reset,
   input  logic   i_miss_start,
   input  addr_t  i_miss_addr,
   output addr_t  o_araddr,
   output logic   o_arvalid,
   input  logic   i_arready,
   input  word_t  i_rdata,
   input  logic   i_rvalid,
   input  logic   i_rlast,
   output logic   o_crit_valid,
   output word_t  o_crit_word,
   output logic   o_fill_we,
   output index_t o_fill_index,
   output tag_t   o_fill_tag,
   output line_t  o_fill_line,
   output logic   o_refill_busy
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_LOAD,
      ST_LOAD_OVER
   } state_t;

   state_t    state_q;
   // slot of the next beat wrapping inside the line
   word_sel_t beat_slot_q;
   // beats taken so far in this burst
   word_sel_t beat_num_q;
   line_t     fill_buf_q;
   logic      beat_take;

   assign beat_take = (state_q == ST_LOAD) && i_rvalid;

   //////////////////////////////
   // miss fsm
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state_q      <= ST_IDLE;
         o_arvalid    <= 1'b0;
         beat_num_q   <= '0;
         o_crit_valid <= 1'b0;
      end else begin
         // first beat carries the missing word
         o_crit_valid <= beat_take && (beat_num_q == '0);
         case (state_q)
            ST_IDLE: begin
               if (i_miss_start) begin
                  o_arvalid  <= 1'b1;
                  beat_num_q <= '0;
                  state_q    <= ST_LOAD;
               end
            end
            ST_LOAD: begin
               if (o_arvalid && i_arready) begin
                  o_arvalid <= 1'b0;
               end
               if (i_rvalid) begin
                  beat_num_q <= beat_num_q + 1'b1;
                  if (i_rlast) begin
                     state_q <= ST_LOAD_OVER;
                  end
               end
            end
            ST_LOAD_OVER: begin
               state_q <= ST_IDLE;
            end
            default: begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

   //////////////////////////////
   // address and fill buffer
   //////////////////////////////

   always_ff @(posedge clk) begin
      if ((state_q == ST_IDLE) && i_miss_start) begin
         o_araddr    <= {i_miss_addr[ADDR_W-1:2], 2'b00};
         beat_slot_q <= addr_word(i_miss_addr);
      end
      if (beat_take) begin
         fill_buf_q[beat_slot_q] <= i_rdata;
         beat_slot_q             <= beat_slot_q + 1'b1;
         if (beat_num_q == '0) begin
            o_crit_word <= i_rdata;
         end
      end
   end

   // line goes to the arrays in load-over
   assign o_fill_we     = (state_q == ST_LOAD_OVER);
   assign o_fill_index  = addr_index(o_araddr);
   assign o_fill_tag    = addr_tag(o_araddr);
   assign o_fill_line   = fill_buf_q;
   assign o_refill_busy = (state_q != ST_IDLE);

   a_addr_hold: assert property (@(posedge clk) disable iff (reset)
      o_arvalid && !i_arready |=> $stable(o_araddr));

   a_no_miss_while_busy: assert property (@(posedge clk) disable iff (reset)
      i_miss_start |-> !o_refill_busy);

   // bus must end the burst on the eighth beat
   a_burst_len: assert property (@(posedge clk) disable iff (reset)
      beat_take |-> (i_rlast == (beat_num_q == word_sel_t'(BURST_BEATS - 1))));

endmodule

/* source/icache_top.sv */
module icache_top import icache_pkg::*; (
   input  logic  clk,
   input  logic  reset,
   input  logic  i_flush,
   input  logic  i_req_valid,
   input  addr_t i_req_addr,
   output logic  o_stall,
   output logic  o_rsp_valid,
   output word_t o_rsp_data,
   output addr_t o_araddr,
   output logic  o_arvalid,
   input  logic  i_arready,
   input  word_t i_rdata,
   input  logic  i_rvalid,
   input  logic  i_rlast
);

   index_t    rd_index;
   tag_t      cmp_tag;
   word_sel_t word_sel;
   way_mask_t hit_way;
   word_t     hit_word;
   logic      miss_start;
   addr_t     miss_addr;
   logic      fill_we;
   index_t    fill_index;
   tag_t      fill_tag;
   line_t     fill_line;
   logic      crit_valid;
   word_t     crit_word;
   logic      refill_busy;

   icache_lookup u_lookup (
      .clk           (clk),
      .reset         (reset),
      .i_req_valid   (i_req_valid),
      .i_req_addr    (i_req_addr),
      .o_rd_index    (rd_index),
      .o_cmp_tag     (cmp_tag),
      .o_word_sel    (word_sel),
      .i_hit_way     (hit_way),
      .i_hit_word    (hit_word),
      .o_miss_start  (miss_start),
      .o_miss_addr   (miss_addr),
      .i_crit_valid  (crit_valid),
      .i_crit_word   (crit_word),
      .i_refill_busy (refill_busy),
      .o_stall       (o_stall),
      .o_rsp_valid   (o_rsp_valid),
      .o_rsp_data    (o_rsp_data)
   );

   icache_arrays u_arrays (
      .clk          (clk),
      .reset        (reset),
      .i_flush      (i_flush),
      .i_rd_index   (rd_index),
      .i_cmp_tag    (cmp_tag),
      .i_word_sel   (word_sel),
      .o_hit_way    (hit_way),
      .o_hit_word   (hit_word),
      .i_fill_we    (fill_we),
      .i_fill_index (fill_index),
      .i_fill_tag   (fill_tag),
      .i_fill_line  (fill_line)
   );

   icache_refill u_refill (
      .clk           (clk),
      .reset         (reset),
      .i_miss_start  (miss_start),
      .i_miss_addr   (miss_addr),
      .o_araddr      (o_araddr),
      .o_arvalid     (o_arvalid),
      .i_arready     (i_arready),
      .i_rdata       (i_rdata),
      .i_rvalid      (i_rvalid),
      .i_rlast       (i_rlast),
      .o_crit_valid  (crit_valid),
      .o_crit_word   (crit_word),
      .o_fill_we     (fill_we),
      .o_fill_index  (fill_index),
      .o_fill_tag    (fill_tag),
      .o_fill_line   (fill_line),
      .o_refill_busy (refill_busy)
   );

endmodule

/* verilog.f */
source/icache_pkg.sv
source/cache_ram.sv
source/icache_arrays.sv
source/icache_refill.sv
source/icache_lookup.sv
source/icache_top.sv
bench/axi_rd_mem.sv
bench/icache_tb.sv
